//--- hdl/ctmm_isa_pkg.sv
// ==================================================
// Instruction set definitions
// Opcode enums, instruction field positions,
// register file and data word sizes
// ==================================================

package ctmm_isa_pkg;

    // Datapath sizes
    localparam int DATA_W      = 64;
    localparam int NREG        = 16;
    localparam int REG_AW      = 4;
    localparam int IMM_W       = 16;
    localparam int LDI_W       = 22;
    localparam int CLIST_IDX_W = 10;

    localparam logic [31:0] NIA_STEP = 32'd4;  // Bytes per instruction

    // Instruction field positions
    localparam int CLASS_BIT    = 31;  // 0 Turing, 1 Church
    localparam int OP_HI        = 30;
    localparam int OP_LO        = 27;
    localparam int DST_HI       = 26;
    localparam int DST_LO       = 23;
    localparam int SRC1_HI      = 22;
    localparam int SRC1_LO      = 19;
    localparam int IMM_FLAG_BIT = 16;

    typedef enum logic [3:0] {
        OP_MOV = 4'd0,
        OP_ADD = 4'd1,
        OP_SUB = 4'd2,
        OP_AND = 4'd3,
        OP_ORR = 4'd4,
        OP_CMP = 4'd5,
        OP_B   = 4'd6,
        OP_LDI = 4'd7
    } turing_op_t;

    typedef enum logic [3:0] {
        OP_LOAD = 4'd0,
        OP_SAVE = 4'd1
    } church_op_t;

endpackage

//--- hdl/ctmm_cap_pkg.sv
// ==================================================
// Capability model definitions
// Golden token layout, permission masks, boot
// states, fault types and boot tokens
// ==================================================

package ctmm_cap_pkg;

    typedef struct packed {
        logic [15:0] perms;
        logic [15:0] spare;
        logic [31:0] offset;  // Low 22 bits form the C-List base
    } golden_token_t;

    // Permission masks
    localparam logic [15:0] PERM_L = 16'h0001;  // Load
    localparam logic [15:0] PERM_S = 16'h0002;  // Save
    localparam logic [15:0] PERM_E = 16'h0004;  // Enter
    localparam logic [15:0] PERM_M = 16'h0008;  // Machine
    localparam logic [15:0] PERM_X = 16'h0010;  // Execute

    localparam golden_token_t GT_NULL = '0;

    typedef enum logic [2:0] {
        BOOT_IDLE      = 3'd0,
        BOOT_FAULT_RST = 3'd1,
        BOOT_LOAD_NS   = 3'd2,
        BOOT_INIT_THRD = 3'd3,
        BOOT_LOAD_NUC  = 3'd4,
        BOOT_COMPLETE  = 3'd5
    } boot_state_t;

    typedef enum logic [1:0] {
        FAULT_NONE    = 2'd0,
        FAULT_ILLEGAL = 2'd1,
        FAULT_PERM    = 2'd2
    } fault_type_t;

    // ==================================================
    // Boot tokens and their target registers
    // ==================================================
    localparam logic [3:0] CR_NS      = 4'd15;
    localparam logic [3:0] CR_THREAD  = 4'd8;
    localparam logic [3:0] CR_CLIST   = 4'd6;
    localparam logic [3:0] CR_NUCLEUS = 4'd7;

    localparam golden_token_t GT_BOOT_NS =
        '{perms: PERM_M | PERM_L, spare: 16'h0, offset: 32'd0};
    localparam golden_token_t GT_BOOT_THREAD =
        '{perms: PERM_M, spare: 16'h0, offset: 32'd3};
    localparam golden_token_t GT_BOOT_CLIST =
        '{perms: PERM_L | PERM_S | PERM_E, spare: 16'h0, offset: 32'd2};
    localparam golden_token_t GT_BOOT_NUCLEUS =
        '{perms: PERM_X, spare: 16'h0, offset: 32'd1};

endpackage

//--- hdl/ctmm_exec_if.sv
// ==================================================
// Decoded operation bus from control to the
// Turing ALU and the capability unit
// ==================================================
`timescale 1ns/10ps

interface ctmm_exec_if;
    import ctmm_isa_pkg::*;
    import ctmm_cap_pkg::*;

    logic              exec;        // Legal instruction accepted this cycle
    logic              is_church;
    turing_op_t        turing_op;
    church_op_t        church_op;
    logic [REG_AW-1:0] dst;
    logic [REG_AW-1:0] src1;
    logic [REG_AW-1:0] src2;
    logic              use_imm;
    logic [IMM_W-1:0]  imm;         // Also carries the C-List index
    logic [LDI_W-1:0]  ldi_imm;
    boot_state_t       boot_state;
    logic              perm_fault;  // Back from the capability unit

    modport ctrl (
        output exec, is_church, turing_op, church_op, dst, src1, src2,
        output use_imm, imm, ldi_imm, boot_state,
        input  perm_fault
    );

    modport alu (
        input exec, is_church, turing_op, dst, src1, src2,
        input use_imm, imm, ldi_imm, boot_state
    );

    modport cap (
        input  exec, is_church, turing_op, church_op, dst, src1, src2,
        input  use_imm, imm, ldi_imm, boot_state,
        output perm_fault
    );

endinterface

//--- hdl/ctmm_control.sv
// ==================================================
// Core control: boot FSM, NIA register,
// instruction decode and fault merging
// ==================================================
`timescale 1ns/10ps

module ctmm_control (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [31:0]               imem_data,
    input  logic                      imem_valid,
    input  logic                      boot_start,
    output logic [31:0]               nia,
    output ctmm_cap_pkg::boot_state_t boot_state,
    output logic                      boot_complete,
    output ctmm_cap_pkg::fault_type_t fault,
    output logic                      fault_valid,
    ctmm_exec_if.ctrl                 ex
);
    import ctmm_isa_pkg::*;
    import ctmm_cap_pkg::*;

    logic        accept;     // Strobe taken after boot
    logic        is_church;
    logic [3:0]  opcode;
    logic        legal;
    logic        illegal;
    logic        is_branch;
    logic [31:0] br_offset;

    // ==================================================
    // Boot sequence
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            boot_state <= BOOT_IDLE;
        end else begin
            case (boot_state)
                BOOT_IDLE: begin
                    if (boot_start) begin
                        boot_state <= BOOT_FAULT_RST;
                    end
                end
                BOOT_FAULT_RST: boot_state <= BOOT_LOAD_NS;
                BOOT_LOAD_NS:   boot_state <= BOOT_INIT_THRD;
                BOOT_INIT_THRD: boot_state <= BOOT_LOAD_NUC;
                BOOT_LOAD_NUC:  boot_state <= BOOT_COMPLETE;
                BOOT_COMPLETE:  boot_state <= BOOT_COMPLETE;  // Stays until reset
                default:        boot_state <= BOOT_IDLE;
            endcase
        end
    end

    assign boot_complete = (boot_state == BOOT_COMPLETE);

    // ==================================================
    // Decode
    // ==================================================
    assign accept    = imem_valid && boot_complete;
    assign is_church = imem_data[CLASS_BIT];
    assign opcode    = imem_data[OP_HI:OP_LO];
    assign legal     = is_church ? (opcode <= 4'(OP_SAVE)) : (opcode <= 4'(OP_LDI));
    assign illegal   = accept && !legal;

    assign ex.exec       = accept && legal;
    assign ex.is_church  = is_church;
    assign ex.turing_op  = turing_op_t'(opcode);
    assign ex.church_op  = church_op_t'(opcode);
    assign ex.dst        = imem_data[DST_HI:DST_LO];
    assign ex.src1       = imem_data[SRC1_HI:SRC1_LO];
    assign ex.src2       = imem_data[REG_AW-1:0];
    assign ex.use_imm    = imem_data[IMM_FLAG_BIT];
    assign ex.imm        = imem_data[IMM_W-1:0];
    assign ex.ldi_imm    = imem_data[LDI_W-1:0];
    assign ex.boot_state = boot_state;

    // Branch offset is a signed byte count
    assign is_branch = ex.exec && !is_church && (ex.turing_op == OP_B);
    assign br_offset = {{(32 - IMM_W){imem_data[IMM_W-1]}}, imem_data[IMM_W-1:0]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nia <= '0;
        end else if (boot_state == BOOT_FAULT_RST) begin
            nia <= '0;
        end else if (is_branch) begin
            nia <= nia + br_offset;
        end else if (accept) begin
            nia <= nia + NIA_STEP;  // Faulting instructions still step
        end
    end

    // Illegal opcode wins over a permission fault
    always_comb begin
        fault       = FAULT_NONE;
        fault_valid = 1'b0;
        if (illegal) begin
            fault       = FAULT_ILLEGAL;
            fault_valid = 1'b1;
        end else if (ex.perm_fault) begin
            fault       = FAULT_PERM;
            fault_valid = 1'b1;
        end
    end

    // Before boot completes only the clear step may move NIA
    a_no_exec_before_boot: assert property (
        @(posedge clk) disable iff (!rst_n)
        !boot_complete && boot_state != BOOT_FAULT_RST |=> $stable(nia)
    );

endmodule

//--- hdl/ctmm_turing_alu.sv
// ==================================================
// Turing datapath: DR0-DR15, Z/N flags and
// the arithmetic and logic operations
// ==================================================
`timescale 1ns/10ps

module ctmm_turing_alu (
    input  logic       clk,
    input  logic       rst_n,
    output logic [1:0] flags,  // {Z, N}
    ctmm_exec_if.alu   ex
);
    import ctmm_isa_pkg::*;
    import ctmm_cap_pkg::*;

    logic [DATA_W-1:0] dr [NREG];
    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] result;
    logic              wr_dr;
    logic              wr_flags;
    logic              turing_exec;

    assign turing_exec = ex.exec && !ex.is_church;
    assign op_a        = dr[ex.src1];
    assign op_b        = ex.use_imm ? DATA_W'(ex.imm) : dr[ex.src2];  // Zero-extended imm

    always_comb begin
        result   = '0;
        wr_dr    = 1'b0;
        wr_flags = 1'b0;
        case (ex.turing_op)
            OP_MOV: begin
                result = op_b;  // Copies the second operand
                wr_dr  = 1'b1;
            end
            OP_ADD: begin
                result   = op_a + op_b;
                wr_dr    = 1'b1;
                wr_flags = 1'b1;
            end
            OP_SUB: begin
                result   = op_a - op_b;
                wr_dr    = 1'b1;
                wr_flags = 1'b1;
            end
            OP_AND: begin
                result   = op_a & op_b;
                wr_dr    = 1'b1;
                wr_flags = 1'b1;
            end
            OP_ORR: begin
                result   = op_a | op_b;
                wr_dr    = 1'b1;
                wr_flags = 1'b1;
            end
            OP_CMP: begin
                result   = op_a - op_b;  // Flags only
                wr_flags = 1'b1;
            end
            OP_LDI: begin
                result = DATA_W'(ex.ldi_imm);
                wr_dr  = 1'b1;
            end
            default: begin
                result = '0;  // B is handled in control
            end
        endcase
    end

    // Register file, wiped during the boot clear step
    always_ff @(posedge clk) begin
        if (ex.boot_state == BOOT_FAULT_RST) begin
            for (int i = 0; i < NREG; i++) begin
                dr[i] <= '0;
            end
        end else if (turing_exec && wr_dr) begin
            dr[ex.dst] <= result;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (ex.boot_state == BOOT_FAULT_RST) begin
            flags <= '0;
        end else if (turing_exec && wr_flags) begin
            flags <= {result == '0, result[DATA_W-1]};
        end
    end

endmodule

//--- hdl/ctmm_cap_unit.sv
// ==================================================
// Church-side capability unit: CR0-CR15, boot
// tokens, permission check and C-List access
// ==================================================
`timescale 1ns/10ps

module ctmm_cap_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    output logic [31:0]                 clist_addr,
    output logic                        clist_rd_en,
    input  ctmm_cap_pkg::golden_token_t clist_rd_data,
    output ctmm_cap_pkg::golden_token_t clist_wr_data,
    output logic                        clist_wr_en,
    ctmm_exec_if.cap                    ex
);
    import ctmm_isa_pkg::*;
    import ctmm_cap_pkg::*;

    golden_token_t cr [NREG];
    golden_token_t addr_cr;    // Capability that names the C-List
    logic [15:0]   need_perms;
    logic          is_load;
    logic          is_save;
    logic          perm_ok;

    assign is_load = ex.exec && ex.is_church && (ex.church_op == OP_LOAD);
    assign is_save = ex.exec && ex.is_church && (ex.church_op == OP_SAVE);

    // SAVE addresses through dst, LOAD through src1
    assign addr_cr    = is_save ? cr[ex.dst] : cr[ex.src1];
    assign need_perms = is_save ? PERM_S : (PERM_L | PERM_M);
    assign perm_ok    = (addr_cr.perms & need_perms) == need_perms;

    assign ex.perm_fault = (is_load || is_save) && !perm_ok;
    assign clist_rd_en   = is_load && perm_ok;
    assign clist_wr_en   = is_save && perm_ok;

    // Offset above the 10-bit index
    assign clist_addr    = {addr_cr.offset[31-CLIST_IDX_W:0], ex.imm[CLIST_IDX_W-1:0]};
    assign clist_wr_data = cr[ex.src1];

    // ==================================================
    // Register file and boot token loading
    // ==================================================
    always_ff @(posedge clk) begin
        case (ex.boot_state)
            BOOT_FAULT_RST: begin
                for (int i = 0; i < NREG; i++) begin
                    cr[i] <= GT_NULL;
                end
            end
            BOOT_LOAD_NS: begin
                cr[CR_NS] <= GT_BOOT_NS;
            end
            BOOT_INIT_THRD: begin
                cr[CR_THREAD] <= GT_BOOT_THREAD;
            end
            BOOT_LOAD_NUC: begin
                cr[CR_CLIST]   <= GT_BOOT_CLIST;
                cr[CR_NUCLEUS] <= GT_BOOT_NUCLEUS;
            end
            default: begin
                if (clist_rd_en) begin
                    cr[ex.dst] <= clist_rd_data;  // Token fetched in the same cycle
                end
            end
        endcase
    end

    // A refused access leaves the named CR as it was
    a_fault_keeps_cr: assert property (
        @(posedge clk) disable iff (!rst_n)
        ex.perm_fault |=> cr[$past(ex.dst)] == $past(cr[ex.dst])
    );

endmodule

//--- hdl/ctmm_core.sv
// ==================================================
// Core top level
// Control, Turing ALU and capability unit joined
// by the decoded operation bus
// ==================================================
`timescale 1ns/10ps

module ctmm_core (
    input  logic                        clk,
    input  logic                        rst_n,

    // Instruction strobe
    input  logic [31:0]                 imem_data,
    input  logic                        imem_valid,

    // C-List memory, combinational read
    output logic [31:0]                 clist_addr,
    output logic                        clist_rd_en,
    input  ctmm_cap_pkg::golden_token_t clist_rd_data,
    output ctmm_cap_pkg::golden_token_t clist_wr_data,
    output logic                        clist_wr_en,

    // Boot
    input  logic                        boot_start,
    output ctmm_cap_pkg::boot_state_t   boot_state,
    output logic                        boot_complete,

    // Status
    output ctmm_cap_pkg::fault_type_t   fault,
    output logic                        fault_valid,
    output logic [31:0]                 nia,
    output logic [1:0]                  flags
);

    ctmm_exec_if ex ();

    ctmm_control u_control (
        .clk           (clk),
        .rst_n         (rst_n),
        .imem_data     (imem_data),
        .imem_valid    (imem_valid),
        .boot_start    (boot_start),
        .nia           (nia),
        .boot_state    (boot_state),
        .boot_complete (boot_complete),
        .fault         (fault),
        .fault_valid   (fault_valid),
        .ex            (ex.ctrl)
    );

    ctmm_turing_alu u_alu (
        .clk   (clk),
        .rst_n (rst_n),
        .flags (flags),
        .ex    (ex.alu)
    );

    ctmm_cap_unit u_cap (
        .clk           (clk),
        .rst_n         (rst_n),
        .clist_addr    (clist_addr),
        .clist_rd_en   (clist_rd_en),
        .clist_rd_data (clist_rd_data),
        .clist_wr_data (clist_wr_data),
        .clist_wr_en   (clist_wr_en),
        .ex            (ex.cap)
    );

endmodule

//--- dv/ctmm_core_tb.sv
// ==================================================
// Testbench for the capability core
// Directed tests, C-List memory model, xorshift
// random source and error summary
// ==================================================
`timescale 1ns/10ps

module ctmm_core_tb;
    import ctmm_isa_pkg::*;
    import ctmm_cap_pkg::*;

    logic          clk;
    logic          rst_n;
    logic [31:0]   imem_data;
    logic          imem_valid;
    logic [31:0]   clist_addr;
    logic          clist_rd_en;
    golden_token_t clist_rd_data;
    golden_token_t clist_wr_data;
    logic          clist_wr_en;
    logic          boot_start;
    boot_state_t   boot_state;
    logic          boot_complete;
    fault_type_t   fault;
    logic          fault_valid;
    logic [31:0]   nia;
    logic [1:0]    flags;

    golden_token_t clist_mem [0:4095];  // C-List model
    logic [31:0]   rng;
    int            errors;
    int            checks;

    // Outputs captured during the strobe cycle
    logic          s_fv;
    fault_type_t   s_fault;
    logic          s_rd;
    logic          s_wr;
    logic [31:0]   s_addr;
    golden_token_t s_wdata;

    ctmm_core uut (.*);

    assign clist_rd_data = clist_mem[clist_addr[11:0]];  // Combinational read

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [31:0] encode(input logic cls, input logic [3:0] op,
                                           input logic [3:0] dst, input logic [3:0] src1,
                                           input logic use_imm, input logic [15:0] imm);
        return {cls, op, dst, src1, 2'b00, use_imm, imm};
    endfunction

    function automatic logic [31:0] encode_ldi(input logic [3:0] dst, input logic [21:0] val);
        return {1'b0, 4'd7, dst, 1'b0, val};
    endfunction

    // Expected {Z, N} for a 64-bit result
    function automatic logic [1:0] zn(input logic [63:0] v);
        return {v == 64'd0, v[63]};
    endfunction

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    // One strobe cycle, then check the NIA step
    task automatic send(input logic [31:0] instr, input logic [31:0] step);
        logic [31:0] nia_before;
        logic [31:0] nia_exp;
        nia_before = nia;
        nia_exp    = nia_before + step;
        imem_data  = instr;
        imem_valid = 1'b1;
        #1;
        s_fv    = fault_valid;
        s_fault = fault;
        s_rd    = clist_rd_en;
        s_wr    = clist_wr_en;
        s_addr  = clist_addr;
        s_wdata = clist_wr_data;
        @(posedge clk);
        if (s_wr) begin
            clist_mem[s_addr[11:0]] = s_wdata;  // Model stores the write
        end
        #2;
        imem_valid = 1'b0;
        check_val("nia", 64'(nia), 64'(nia_exp));
    endtask

    task automatic test_boot();
        boot_state_t seq [5];
        int          edges;
        seq = '{BOOT_FAULT_RST, BOOT_LOAD_NS, BOOT_INIT_THRD, BOOT_LOAD_NUC, BOOT_COMPLETE};
        check_val("boot_state", 64'(boot_state), 64'(BOOT_IDLE));
        check_val("boot_complete", 64'(boot_complete), 64'd0);
        check_val("fault_valid", 64'(fault_valid), 64'd0);
        check_val("clist_rd_en", 64'(clist_rd_en), 64'd0);
        check_val("clist_wr_en", 64'(clist_wr_en), 64'd0);
        check_val("nia", 64'(nia), 64'd0);
        send(encode(1'b0, OP_ADD, 4'd1, 4'd1, 1'b1, 16'd5), 32'd0);  // Ignored
        boot_start = 1'b1;
        edges      = 0;
        while (!boot_complete && edges < 20) begin
            @(posedge clk);
            #2;
            boot_start = 1'b0;
            if (edges < 5) begin
                check_val("boot_state", 64'(boot_state), 64'(seq[edges]));
            end
            edges++;
        end
        assert (boot_complete) else begin
            errors++;
            $display("Timeout: boot_complete did not rise within 20 cycles");
        end
        check_val("boot edges", 64'(edges), 64'd5);
        boot_start = 1'b1;  // Must be ignored once complete
        @(posedge clk);
        #2;
        boot_start = 1'b0;
        check_val("boot_state", 64'(boot_state), 64'(BOOT_COMPLETE));
    endtask

    task automatic test_move_compare();
        logic [21:0] r;
        logic [15:0] imm;
        r   = 22'(xorshift());
        imm = r[15:0] + 16'd1;
        send(encode_ldi(4'd1, r), NIA_STEP);
        send(encode(1'b0, OP_MOV, 4'd2, 4'd0, 1'b0, 16'd1), NIA_STEP);
        send(encode(1'b0, OP_CMP, 4'd0, 4'd2, 1'b0, 16'd1), NIA_STEP);  // DR2 vs DR1
        check_val("flags", 64'(flags), 64'(2'b10));
        send(encode(1'b0, OP_CMP, 4'd0, 4'd2, 1'b1, imm), NIA_STEP);
        check_val("flags", 64'(flags), 64'(zn(64'(r) - 64'(imm))));
        check_val("flags.z", 64'(flags[1]), 64'd0);
    endtask

    task automatic test_alu_flags();
        logic [63:0] a;
        logic [63:0] b;
        a = 64'd100;
        b = 64'd30;
        send(encode_ldi(4'd3, a[21:0]), NIA_STEP);
        send(encode_ldi(4'd4, b[21:0]), NIA_STEP);
        send(encode(1'b0, OP_ADD, 4'd5, 4'd3, 1'b0, 16'd4), NIA_STEP);
        check_val("flags add", 64'(flags), 64'(zn(a + b)));
        send(encode(1'b0, OP_SUB, 4'd6, 4'd4, 1'b0, 16'd3), NIA_STEP);  // Goes negative
        check_val("flags sub", 64'(flags), 64'(zn(b - a)));
        check_val("flags.n", 64'(flags[0]), 64'd1);
        send(encode(1'b0, OP_AND, 4'd7, 4'd3, 1'b1, 16'h001b), NIA_STEP);
        check_val("flags and", 64'(flags), 64'(zn(a & 64'h1b)));
        check_val("flags.z", 64'(flags[1]), 64'd1);
        send(encode(1'b0, OP_ORR, 4'd8, 4'd3, 1'b0, 16'd4), NIA_STEP);
        check_val("flags orr", 64'(flags), 64'(zn(a | b)));
    endtask

    task automatic test_branch();
        send(encode(1'b0, OP_B, 4'd0, 4'd0, 1'b0, 16'h0040), 32'h0000_0040);
        send(encode(1'b0, OP_B, 4'd0, 4'd0, 1'b0, 16'hffe8), 32'hffff_ffe8);  // Back 24
    endtask

    task automatic test_capabilities();
        logic [9:0]    k;
        logic [9:0]    j;
        golden_token_t tok;
        k   = 10'(xorshift());
        j   = 10'(xorshift());
        tok = clist_mem[{2'b00, k}];
        send(encode(1'b1, OP_LOAD, 4'd1, 4'd15, 1'b0, {6'd0, k}), NIA_STEP);
        check_val("clist_rd_en", 64'(s_rd), 64'd1);
        check_val("clist_wr_en", 64'(s_wr), 64'd0);
        check_val("clist_addr", 64'(s_addr), 64'(k));
        check_val("fault_valid", 64'(s_fv), 64'd0);
        send(encode(1'b1, OP_SAVE, 4'd6, 4'd1, 1'b0, {6'd0, j}), NIA_STEP);
        check_val("clist_wr_en", 64'(s_wr), 64'd1);
        check_val("clist_rd_en", 64'(s_rd), 64'd0);
        check_val("clist_addr", 64'(s_addr), 64'(12'd2048 + {2'b00, j}));
        check_val("clist_wr_data", s_wdata, tok);
        check_val("clist_mem", clist_mem[12'd2048 + {2'b00, j}], tok);
    endtask

    task automatic test_faults();
        send(encode(1'b1, OP_LOAD, 4'd2, 4'd6, 1'b0, 16'd5), NIA_STEP);  // CR6 lacks M
        check_val("fault_valid", 64'(s_fv), 64'd1);
        check_val("fault", 64'(s_fault), 64'(FAULT_PERM));
        check_val("clist_rd_en", 64'(s_rd), 64'd0);
        send(encode(1'b1, OP_SAVE, 4'd6, 4'd2, 1'b0, 16'd7), NIA_STEP);  // CR2 untouched
        check_val("fault_valid", 64'(s_fv), 64'd0);
        check_val("clist_wr_en", 64'(s_wr), 64'd1);
        check_val("clist_wr_data", s_wdata, GT_NULL);
        send(encode(1'b1, OP_SAVE, 4'd15, 4'd1, 1'b0, 16'd8), NIA_STEP);  // CR15 lacks S
        check_val("fault_valid", 64'(s_fv), 64'd1);
        check_val("fault", 64'(s_fault), 64'(FAULT_PERM));
        check_val("clist_wr_en", 64'(s_wr), 64'd0);
        send(encode(1'b0, 4'd9, 4'd1, 4'd1, 1'b0, 16'd0), NIA_STEP);
        check_val("fault_valid", 64'(s_fv), 64'd1);
        check_val("fault", 64'(s_fault), 64'(FAULT_ILLEGAL));
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        rst_n      = 1'b0;
        imem_data  = '0;
        imem_valid = 1'b0;
        boot_start = 1'b0;
        errors     = 0;
        checks     = 0;
        rng        = 32'hf3af;
        for (int i = 0; i < 4096; i++) begin
            clist_mem[i] = {xorshift(), xorshift()};
        end
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_boot();
        test_move_compare();
        test_alu_flags();
        test_branch();
        test_capabilities();
        test_faults();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- files.f
hdl/ctmm_isa_pkg.sv
hdl/ctmm_cap_pkg.sv
hdl/ctmm_exec_if.sv
hdl/ctmm_control.sv
hdl/ctmm_turing_alu.sv
hdl/ctmm_cap_unit.sv
hdl/ctmm_core.sv
dv/ctmm_core_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/10ps
TOP      := ctmm_core_tb
FILELIST := files.f
OBJ_DIR  := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove build output"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf $(OBJ_DIR)
